// ==== Makefile ====
# Verilator build and run for the channel scanner testbench

VERILATOR ?= verilator
TOP       ?= tb_channel_scanner
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== channel_scanner_top.sv ====
`timescale 1ns/100ps

module channel_scanner_top (
   input  logic                                                clk,
   input  logic                                                rst,
   input  logic                                                go,
   input  mux_pkg::chan_mask_t                                 enable_mask,
   input  logic [mux_pkg::NUM_CHANNELS*mux_pkg::DATA_WIDTH-1:0] channel_data,
   output mux_pkg::data_t                                      sample_data,
   output logic                                                sample_valid,
   output mux_pkg::chan_t                                      sample_channel,
   output logic                                                busy,
   output logic                                                done
);

   // Tree select from the sequencer
   mux_pkg::tag_t tag;

   scan_sequencer u_seq (
      .clk            (clk),
      .rst            (rst),
      .go             (go),
      .enable_mask    (enable_mask),
      .tag            (tag),
      .sample_valid   (sample_valid),
      .sample_channel (sample_channel),
      .busy           (busy),
      .done           (done)
   );

   // Channel 0 sits in the low bits of channel_data
   mux_tree #(
      .N     (mux_pkg::NUM_CHANNELS),
      .WIDTH (mux_pkg::DATA_WIDTH)
   ) u_tree (
      .clk    (clk),
      .rst    (rst),
      .sel    (tag),
      .ins    (channel_data),
      .result (sample_data)
   );

endmodule

// ==== mux_pkg.sv ====
package mux_pkg;

   // Pad leaves so that every internal node has four children
   function automatic int pad_leaves(int n);
      if (n % 3 == 1) begin
         return n;
      end
      return (n % 3 == 0) ? n + 1 : n + 2;
   endfunction

   // Ceiling of log base 4
   function automatic int tree_height(int leaves);
      return ($clog2(leaves) + 1) / 2;
   endfunction

   function automatic int node_count(int leaves);
      return leaves + (leaves - 1) / 3;
   endfunction

   // Leaves entering the deepest level directly, the rest come in one level higher
   function automatic int long_path_leaves(int n);
      int leaves;
      int full;
      leaves = pad_leaves(n);
      full = node_count(leaves) - (4 ** tree_height(leaves) - 1) / 3;
      return (n < full) ? n : full;
   endfunction

   // Distance from the root of the node at reverse heap index r
   function automatic int tree_depth(int r);
      int depth;
      int covered;
      int span;
      depth = 0;
      covered = 1;
      span = 1;
      while (r >= covered) begin
         span = span * 4;
         covered = covered + span;
         depth = depth + 1;
      end
      return depth;
   endfunction

   localparam int NUM_CHANNELS     = 6;
   localparam int DATA_WIDTH       = 16;
   localparam int TREE_LEAVES      = pad_leaves(NUM_CHANNELS);
   localparam int TREE_HEIGHT      = tree_height(TREE_LEAVES);
   localparam int TAG_WIDTH        = 2 * TREE_HEIGHT;
   localparam int TREE_NODES       = node_count(TREE_LEAVES);
   localparam int LONG_PATH_LEAVES = long_path_leaves(NUM_CHANNELS);
   localparam int TREE_LATENCY     = TREE_HEIGHT;
   localparam int CHAN_WIDTH       = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

   typedef logic [DATA_WIDTH-1:0]   data_t;
   typedef logic [TAG_WIDTH-1:0]    tag_t;
   typedef logic [CHAN_WIDTH-1:0]   chan_t;
   typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

   typedef enum logic [1:0] {
      IDLE,
      SCAN,
      FLUSH
   } scan_state_t;

endpackage

// ==== mux_tree.sv ====
`timescale 1ns/100ps

module mux_tree #(
   parameter int  N      = 4,
   parameter int  WIDTH  = 32,
   localparam int PADDED = mux_pkg::pad_leaves(N),
   localparam int HEIGHT = mux_pkg::tree_height(PADDED),
   localparam int TAG_SZ = 2 * HEIGHT
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [TAG_SZ-1:0] sel,
   input  logic [N*WIDTH-1:0] ins,
   output logic [WIDTH-1:0]  result
);

   localparam int NUM_NODES = mux_pkg::node_count(PADDED);
   localparam int INTERNAL  = (PADDED - 1) / 3;
   localparam int CUTOFF    = mux_pkg::long_path_leaves(N);

   // Heap order: leaves first, then internal nodes, root last
   wire [WIDTH-1:0] nodes [NUM_NODES];

   // sel_pipe[k] is the select delayed by k cycles
   logic [TAG_SZ-1:0] sel_pipe [HEIGHT];

   assign sel_pipe[0] = sel;

   for (genvar k = 1; k < HEIGHT; k++) begin : g_sel_pipe
      always_ff @(posedge clk) begin
         if (rst) begin
            sel_pipe[k] <= '0;
         end else begin
            sel_pipe[k] <= sel_pipe[k-1];
         end
      end
   end

   // Leaves entering the deepest level
   for (genvar i = 0; i < CUTOFF; i++) begin : g_long_leaf
      assign nodes[i] = ins[i*WIDTH +: WIDTH];
   end

   // Leaves entering one level up need a stage to line up with the rest
   for (genvar i = CUTOFF; i < N; i++) begin : g_short_leaf
      logic [WIDTH-1:0] leaf_q;

      always_ff @(posedge clk) begin
         if (rst) begin
            leaf_q <= '0;
         end else begin
            leaf_q <= ins[i*WIDTH +: WIDTH];
         end
      end

      assign nodes[i] = leaf_q;
   end

   // Zero pad up to one more than a multiple of three
   for (genvar i = N; i < PADDED; i++) begin : g_pad
      assign nodes[i] = '0;
   end

   for (genvar i = 0; i < INTERNAL; i++) begin : g_node
      // LEVEL 0 is the deepest level and uses tag bits 1:0
      localparam int DEPTH = mux_pkg::tree_depth(NUM_NODES - 1 - (PADDED + i));
      localparam int LEVEL = HEIGHT - 1 - DEPTH;

      mux_tree_node #(
         .WIDTH        (WIDTH),
         .ENABLE_DELAY (1'b1)
      ) u_node (
         .clk    (clk),
         .rst    (rst),
         .sel    (sel_pipe[LEVEL][2*LEVEL +: 2]),
         .a      (nodes[4*i]),
         .b      (nodes[4*i+1]),
         .c      (nodes[4*i+2]),
         .d      (nodes[4*i+3]),
         .result (nodes[PADDED+i])
      );
   end

   assign result = nodes[NUM_NODES-1];

endmodule

// ==== mux_tree_node.sv ====
`timescale 1ns/100ps

module mux_tree_node #(
   parameter int WIDTH        = 32,
   parameter bit ENABLE_DELAY = 1'b1
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [1:0]       sel,
   input  logic [WIDTH-1:0] a,
   input  logic [WIDTH-1:0] b,
   input  logic [WIDTH-1:0] c,
   input  logic [WIDTH-1:0] d,
   output logic [WIDTH-1:0] result
);

   logic [WIDTH-1:0] choice;

   always_comb begin
      case (sel)
         2'd0:    choice = a;
         2'd1:    choice = b;
         2'd2:    choice = c;
         default: choice = d;
      endcase
   end

   if (ENABLE_DELAY) begin : g_reg
      // One pipeline stage per node
      always_ff @(posedge clk) begin
         if (rst) begin
            result <= '0;
         end else begin
            result <= choice;
         end
      end
   end else begin : g_comb
      // Combinational node, clk and rst go unused
      assign result = choice;
   end

endmodule

// ==== scan_sequencer.sv ====
`timescale 1ns/100ps

module scan_sequencer (
   input  logic                clk,
   input  logic                rst,
   input  logic                go,
   input  mux_pkg::chan_mask_t enable_mask,
   output mux_pkg::tag_t       tag,
   output logic                sample_valid,
   output mux_pkg::chan_t      sample_channel,
   output logic                busy,
   output logic                done
);

   localparam int LAT = mux_pkg::TREE_LATENCY;

   typedef logic [mux_pkg::NUM_CHANNELS-1:0][mux_pkg::TAG_WIDTH-1:0] tag_table_t;

   // Walk each leaf up to the root and collect the select at every level
   function automatic tag_table_t build_tag_table();
      tag_table_t tbl;
      int node;
      int parent;
      int level;
      tbl = '0;
      for (int ch = 0; ch < mux_pkg::NUM_CHANNELS; ch++) begin
         node = ch;
         while (node != mux_pkg::TREE_NODES - 1) begin
            parent = mux_pkg::TREE_LEAVES + node / 4;
            level = mux_pkg::TREE_HEIGHT - 1
                    - mux_pkg::tree_depth(mux_pkg::TREE_NODES - 1 - parent);
            tbl[ch][2*level +: 2] = 2'(node % 4);
            node = parent;
         end
      end
      return tbl;
   endfunction

   localparam tag_table_t TAG_TABLE = build_tag_table();

   mux_pkg::scan_state_t state;
   mux_pkg::chan_mask_t  pending;
   mux_pkg::chan_mask_t  pending_next;
   mux_pkg::chan_t       next_chan;
   logic                 tag_valid;
   mux_pkg::chan_t       tag_chan;
   logic [LAT-1:0]       valid_pipe;
   mux_pkg::chan_t       chan_pipe [LAT];
   logic                 in_flight;

   // Lowest channel still waiting in this scan
   always_comb begin
      next_chan = '0;
      for (int i = mux_pkg::NUM_CHANNELS - 1; i >= 0; i--) begin
         if (pending[i]) begin
            next_chan = mux_pkg::chan_t'(i);
         end
      end
      pending_next = pending;
      pending_next[next_chan] = 1'b0;
   end

   // The last stage drains on the same edge that returns to IDLE
   always_comb begin
      in_flight = tag_valid && (LAT > 1);
      for (int i = 0; i < LAT - 2; i++) begin
         in_flight = in_flight | valid_pipe[i];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= mux_pkg::IDLE;
         pending   <= '0;
         tag       <= '0;
         tag_valid <= 1'b0;
         busy      <= 1'b0;
         done      <= 1'b0;
      end else begin
         done      <= 1'b0;
         tag_valid <= 1'b0;
         case (state)
            mux_pkg::IDLE: begin
               if (go) begin
                  if (enable_mask != '0) begin
                     pending <= enable_mask;
                     busy    <= 1'b1;
                     state   <= mux_pkg::SCAN;
                  end else begin
                     // Nothing enabled, finish at once
                     done <= 1'b1;
                  end
               end
            end
            mux_pkg::SCAN: begin
               tag       <= TAG_TABLE[next_chan];
               tag_valid <= 1'b1;
               pending   <= pending_next;
               if (pending_next == '0) begin
                  state <= mux_pkg::FLUSH;
               end
            end
            mux_pkg::FLUSH: begin
               if (!in_flight) begin
                  busy  <= 1'b0;
                  done  <= 1'b1;
                  state <= mux_pkg::IDLE;
               end
            end
            default: state <= mux_pkg::IDLE;
         endcase
      end
   end

   // Valid runs alongside the tree pipeline
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_pipe <= '0;
      end else begin
         valid_pipe[0] <= tag_valid;
         for (int i = 1; i < LAT; i++) begin
            valid_pipe[i] <= valid_pipe[i-1];
         end
      end
   end

   // Channel numbers follow the same stages, qualified by valid
   always_ff @(posedge clk) begin
      tag_chan     <= next_chan;
      chan_pipe[0] <= tag_chan;
      for (int i = 1; i < LAT; i++) begin
         chan_pipe[i] <= chan_pipe[i-1];
      end
   end

   assign sample_valid   = valid_pipe[LAT-1];
   assign sample_channel = chan_pipe[LAT-1];

endmodule

// ==== src.f ====
mux_pkg.sv
mux_tree_node.sv
mux_tree.sv
scan_sequencer.sv
channel_scanner_top.sv
tb_clock_gen.sv
tb_channel_scanner.sv

// ==== tb_channel_scanner.sv ====
`timescale 1ns/100ps

module tb_channel_scanner;

   localparam int NCH             = mux_pkg::NUM_CHANNELS;
   localparam int DW              = mux_pkg::DATA_WIDTH;
   localparam int LAT             = mux_pkg::TREE_LATENCY;
   localparam int HIST_BITS       = 5;
   localparam int HIST_DEPTH      = 1 << HIST_BITS;
   localparam int NUM_SCANS       = 210;
   localparam int WATCHDOG_CYCLES = NUM_SCANS * (NCH + LAT + 4) + 100;

   logic                clk;
   logic                rst;
   logic                go;
   mux_pkg::chan_mask_t enable_mask;
   logic [NCH*DW-1:0]   channel_data;
   mux_pkg::data_t      sample_data;
   logic                sample_valid;
   mux_pkg::chan_t      sample_channel;
   logic                busy;
   logic                done;

   // Channel data driven in each cycle and captured by the following rising edge
   logic [NCH*DW-1:0] data_hist [HIST_DEPTH];

   // Expected samples in arrival order
   int exp_cyc_q[$];
   int exp_chan_q[$];
   int exp_src_q[$];

   int    done_cyc;
   int    busy_from;
   int    busy_to;
   int    cyc;
   int    sample_count;
   int    extra_go;
   int    go_cyc;
   string test_name;

   tb_clock_gen #(
      .PERIOD_NS (20)
   ) u_clock_gen (
      .clk (clk)
   );

   channel_scanner_top u_channel_scanner_top (
      .clk            (clk),
      .rst            (rst),
      .go             (go),
      .enable_mask    (enable_mask),
      .channel_data   (channel_data),
      .sample_data    (sample_data),
      .sample_valid   (sample_valid),
      .sample_channel (sample_channel),
      .busy           (busy),
      .done           (done)
   );

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("Mismatch in %s, %s: expected %0h, actual %0h",
                  test_name, name, expected, actual);
         $display("TB FAILED");
         $fatal(1, "Stopped at first error");
      end
   endtask

   function automatic logic [HIST_BITS-1:0] hist_idx(input int c);
      return HIST_BITS'(c);
   endfunction

   function automatic int count_ones(input mux_pkg::chan_mask_t mask);
      int n;
      n = 0;
      for (int ch = 0; ch < NCH; ch++) begin
         if (mask[ch]) begin
            n++;
         end
      end
      return n;
   endfunction

   function automatic mux_pkg::chan_mask_t random_mask();
      mux_pkg::chan_mask_t mask;
      do begin
         mask = mux_pkg::chan_mask_t'($urandom);
      end while (mask == '0);
      return mask;
   endfunction

   // Outputs seen at a falling edge reflect the rising edge just before it
   task automatic observe_outputs();
      logic              exp_valid;
      logic [NCH*DW-1:0] src_bus;
      exp_valid = (exp_cyc_q.size() > 0) && (exp_cyc_q[0] == cyc);
      check_value("sample_valid", 64'(exp_valid), 64'(sample_valid));
      if (sample_valid === 1'b1) begin
         sample_count++;
      end
      if (exp_valid) begin
         src_bus = data_hist[hist_idx(exp_src_q[0])];
         check_value("sample_channel", 64'(exp_chan_q[0]), 64'(sample_channel));
         check_value("sample_data", 64'(src_bus[exp_chan_q[0]*DW +: DW]), 64'(sample_data));
         exp_cyc_q.delete(0);
         exp_chan_q.delete(0);
         exp_src_q.delete(0);
      end
      check_value("busy", 64'(cyc >= busy_from && cyc <= busy_to), 64'(busy));
      check_value("done", 64'(cyc == done_cyc), 64'(done));
   endtask

   task automatic step();
      @(negedge clk);
      cyc++;
      observe_outputs();
      go          = 1'b0;
      enable_mask = mux_pkg::chan_mask_t'($urandom);
      for (int ch = 0; ch < NCH; ch++) begin
         channel_data[ch*DW +: DW] = mux_pkg::data_t'($urandom);
      end
      data_hist[hist_idx(cyc)] = channel_data;
   endtask

   // go driven in cycle g is sampled by the rising edge that ends cycle g
   task automatic schedule_scan(input int g, input mux_pkg::chan_mask_t mask);
      int k;
      k = 0;
      for (int ch = 0; ch < NCH; ch++) begin
         if (mask[ch]) begin
            // Tag k registers at the edge ending cycle g+1+k and its data one edge later
            exp_cyc_q.push_back(g + 2 + k + LAT);
            exp_chan_q.push_back(ch);
            exp_src_q.push_back(g + 2 + k);
            k++;
         end
      end
      if (k == 0) begin
         done_cyc = g + 1;
      end else begin
         busy_from = g + 1;
         busy_to   = g + k + LAT;
         done_cyc  = g + k + LAT + 1;
      end
   endtask

   task automatic clear_expectations();
      exp_cyc_q.delete();
      exp_chan_q.delete();
      exp_src_q.delete();
      done_cyc = -1;
      busy_to  = cyc;
   endtask

   task automatic start_scan(input mux_pkg::chan_mask_t mask);
      step();
      go_cyc       = cyc;
      go           = 1'b1;
      enable_mask  = mask;
      sample_count = 0;
      schedule_scan(go_cyc, mask);
   endtask

   // busy_go_at is the cycle after go for a second pulse or 0 for none
   task automatic run_scan(input mux_pkg::chan_mask_t mask, input int busy_go_at);
      start_scan(mask);
      do begin
         step();
         if (cyc - go_cyc == busy_go_at) begin
            go = 1'b1;
         end
      end while (done !== 1'b1);
      check_value("sample count", 64'(count_ones(mask)), 64'(sample_count));
      repeat ($urandom % 3) step();
   endtask

   initial begin
      mux_pkg::chan_mask_t mask;
      void'($urandom(32'hedcc_f0dc));
      rst          = 1'b1;
      go           = 1'b0;
      enable_mask  = '0;
      channel_data = '0;
      cyc          = 0;
      done_cyc     = -1;
      busy_from    = 1;
      busy_to      = 0;
      sample_count = 0;
      for (int i = 0; i < HIST_DEPTH; i++) begin
         data_hist[i] = '0;
      end

      test_name = "reset";
      repeat (4) step();
      check_value("sample_valid", 64'd0, 64'(sample_valid));
      check_value("busy", 64'd0, 64'(busy));
      check_value("done", 64'd0, 64'(done));
      check_value("sample_data", 64'd0, 64'(sample_data));
      rst = 1'b0;

      test_name = "full mask";
      run_scan('1, 0);

      test_name = "zero mask";
      repeat (3) run_scan('0, 0);

      test_name = "random masks";
      repeat (200) run_scan(random_mask(), 0);

      test_name = "go while busy";
      repeat (4) begin
         mask     = random_mask();
         extra_go = 1 + int'($urandom % (count_ones(mask) + LAT));
         run_scan(mask, extra_go);
      end

      test_name = "reset mid-scan";
      start_scan('1);
      repeat (LAT + 2) step();
      rst = 1'b1;
      clear_expectations();
      repeat (4) step();
      rst = 1'b0;

      test_name = "scan after reset";
      run_scan(random_mask(), 0);

      $display("TB PASSED");
      $finish;
   end

   // Each scan takes at most NCH + LAT + 4 cycles including the gap after it
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $fatal(1, "Watchdog expired");
   end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int PERIOD_NS = 20
) (
   output logic clk
);

   // Free running clock, low for the first half period
   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

endmodule
